// ==== src/io_params.svh ====
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Host data bus width
`define IO_DATA_W 8

// Host address bits 7 to 4
`define IO_ADDR_W 4

// Slot codes 6 and 7 select nothing
`define IO_SLOT_COUNT 6

// Constant byte at the system type address
`define IO_SYSTYPE_VAL 8'h40

// Coin and test switch bits, neutral
`define IO_STATUS_FILL 6'b111111

`endif

// ==== src/ioPkg.sv ====
package ioPkg;

	// Decoded register behind the current bus address
	typedef enum logic [2:0]
	{
		regDip      = 3'd0,   // DIP switch bank, read only
		regSysType  = 3'd1,   // Fixed system type byte
		regStatus   = 3'd2,   // Calendar lines plus fill bits
		regSlot     = 3'd3,   // Cartridge slot number
		regLedLatch = 3'd4,   // LED latch strobes
		regLedData  = 3'd5,   // LED segment data
		regRtcCtrl  = 3'd6,   // Calendar serial control lines
		regNone     = 3'd7    // Unmapped address
	} regSel;

	// Wishbone slave handshake states
	typedef enum logic [1:0]
	{
		busIdle = 2'd0,       // Waiting for cyc and stb
		busAck  = 2'd1,       // Ack high this cycle
		busWait = 2'd2        // Ack done, stb still high
	} busState;

endpackage

// ==== src/busSlave.sv ====
`timescale 1ns/100ps

`include "io_params.svh"

module busSlave
(
	input  logic                  nBITWD0,
	input  logic                  reset,
	input  logic                  wbCyc,
	input  logic                  wbStb,
	input  logic                  wbWe,
	input  logic [`IO_ADDR_W-1:0] wbAdr,
	output logic [`IO_DATA_W-1:0] wbDatOut,
	output logic                  wbAck,
	output ioPkg::regSel          sel,
	output logic                  wrEn,
	input  logic [`IO_DATA_W-1:0] rdData
);

	import ioPkg::*;

	busState state;
	logic    req;   // Master is requesting

	assign req = wbCyc && wbStb;

	// Handshake FSM, one ack per request
	always_ff @(posedge nBITWD0)
	begin
		if (reset)
			state <= busIdle;
		else
		begin
			case (state)
				busIdle: if (req) state <= busAck;
				busAck:  state <= req ? busWait : busIdle;  // Master may drop stb at once
				busWait: if (!req) state <= busIdle;
				default: state <= busIdle;
			endcase
		end
	end

	assign wbAck = (state == busAck);
	assign wrEn  = wbAck && wbWe;                           // Register write on the ack edge
	assign wbDatOut = wbAck ? rdData : '0;                  // Only valid with ack

	// Address decode, wbAdr[2:0] is CPU A6..A4
	always_comb
	begin
		case (wbAdr[2:0])
			3'b000:  sel = wbAdr[3] ? regSysType : regDip;  // A7 picks system type
			3'b001:  sel = regStatus;
			3'b010:  sel = regSlot;
			3'b011:  sel = regLedLatch;
			3'b100:  sel = regLedData;
			3'b101:  sel = regRtcCtrl;
			default: sel = regNone;
		endcase
	end

	// Ack only while the master still holds the request
	ackNeedsReq: assert property (@(posedge nBITWD0) disable iff (reset)
		wbAck |-> (wbCyc && wbStb));

	// Single cycle ack
	ackOneCycle: assert property (@(posedge nBITWD0) disable iff (reset)
		wbAck |=> !wbAck);

endmodule

// ==== src/inputSync.sv ====
`timescale 1ns/100ps

`include "io_params.svh"

module inputSync
(
	input  logic                  nBITWD0,
	input  logic                  reset,
	input  logic [`IO_DATA_W-1:0] dipSw,
	input  logic                  rtcDout,
	input  logic                  rtcTp,
	input  logic                  systemB,
	output logic [`IO_DATA_W-1:0] dipSync,
	output logic [`IO_DATA_W-1:0] statusByte,
	output logic                  systemBSync
);

	logic [`IO_DATA_W-1:0] dipMeta;   // First stage
	logic [1:0]            rtcMeta;   // {dout, tp}
	logic [1:0]            rtcSync;
	logic                  sysBMeta;

	// DIP and calendar line synchronizers
	always_ff @(posedge nBITWD0)
	begin
		if (reset)
		begin
			dipMeta <= '0;
			dipSync <= '0;
			rtcMeta <= '0;
			rtcSync <= '0;
		end
		else
		begin
			dipMeta <= dipSw;
			dipSync <= dipMeta;
			rtcMeta <= {rtcDout, rtcTp};
			rtcSync <= rtcMeta;
		end
	end

	// systemB synchronizer
	always_ff @(posedge nBITWD0)
	begin
		sysBMeta    <= systemB;
		systemBSync <= sysBMeta;
	end

	assign statusByte = {rtcSync, `IO_STATUS_FILL};   // Calendar in bits 7 and 6

endmodule

// ==== src/ioRegisters.sv ====
`timescale 1ns/100ps

`include "io_params.svh"

module ioRegisters
(
	input  logic                  nBITWD0,
	input  logic                  reset,
	input  logic                  wrEn,
	input  ioPkg::regSel          sel,
	input  logic [`IO_DATA_W-1:0] wrData,
	input  logic [`IO_DATA_W-1:0] dipSync,
	input  logic [`IO_DATA_W-1:0] statusByte,
	output logic [`IO_DATA_W-1:0] rdData,
	output logic [2:0]            slotCode,
	output logic [2:0]            ledLatchReg,
	output logic [`IO_DATA_W-1:0] ledDataReg,
	output logic [2:0]            rtcCtrlReg
);

	import ioPkg::*;

	localparam int PadW = `IO_DATA_W - 3;   // Zero pad for 3-bit fields

	// Register writes on the ack edge
	always_ff @(posedge nBITWD0)
	begin
		if (reset)
		begin
			slotCode    <= '0;   // Slot 0 selected
			ledLatchReg <= '0;
			ledDataReg  <= '0;
			rtcCtrlReg  <= '0;
		end
		else if (wrEn)
		begin
			case (sel)
				regSlot:     slotCode    <= wrData[2:0];
				regLedLatch: ledLatchReg <= wrData[5:3];   // Strobes sit in D5..D3
				regLedData:  ledDataReg  <= wrData;
				regRtcCtrl:  rtcCtrlReg  <= wrData[2:0];   // Strobe, clk, din
				default:     ;                              // Read only or unmapped
			endcase
		end
	end

	// Read mux
	always_comb
	begin
		case (sel)
			regDip:      rdData = dipSync;
			regSysType:  rdData = `IO_SYSTYPE_VAL;
			regStatus:   rdData = statusByte;
			regSlot:     rdData = {{PadW{1'b0}}, slotCode};
			regLedLatch: rdData = {{PadW{1'b0}}, ledLatchReg};   // Read back unshifted
			regLedData:  rdData = ledDataReg;
			regRtcCtrl:  rdData = {{PadW{1'b0}}, rtcCtrlReg};
			default:     rdData = '1;
		endcase
	end

endmodule

// ==== src/boardOutputs.sv ====
`timescale 1ns/100ps

`include "io_params.svh"

module boardOutputs
(
	input  logic                      nBITWD0,
	input  logic                      reset,
	input  logic [2:0]                slotCode,
	input  logic                      systemBSync,
	input  logic [2:0]                ledLatchReg,
	input  logic [`IO_DATA_W-1:0]     ledDataReg,
	input  logic [2:0]                rtcCtrlReg,
	output logic [`IO_SLOT_COUNT-1:0] nSlot,
	output logic                      slotA,
	output logic                      slotB,
	output logic                      slotC,
	output logic [2:0]                ledLatch,
	output logic [`IO_DATA_W-1:0]     ledData,
	output logic                      rtcDin,
	output logic                      rtcClk,
	output logic                      rtcStrobe
);

	localparam int SlotN = `IO_SLOT_COUNT;

	logic [SlotN-1:0] nSlotNext;
	logic             slotValid;   // Codes 0 to 5

	assign slotValid = slotCode < 3'(SlotN);

	// One-cold enable gated by systemB
	always_comb
	begin
		if (systemBSync && slotValid)
			nSlotNext = ~(SlotN'(1) << slotCode);
		else
			nSlotNext = '1;   // Invalid code or no systemB
	end

	// Slot enables and slot code lines
	always_ff @(posedge nBITWD0)
	begin
		nSlot               <= nSlotNext;
		{slotC, slotB, slotA} <= systemBSync ? slotCode : 3'b000;
	end

	// LED and calendar lines
	always_ff @(posedge nBITWD0)
	begin
		if (reset)
		begin
			ledLatch                     <= '0;
			ledData                      <= '0;
			{rtcStrobe, rtcClk, rtcDin} <= '0;
		end
		else
		begin
			ledLatch                     <= ledLatchReg;
			ledData                      <= ledDataReg;
			{rtcStrobe, rtcClk, rtcDin} <= rtcCtrlReg;   // Bit 0 is din
		end
	end

	// Never two slots enabled
	oneSlotMax: assert property (@(posedge nBITWD0) disable iff (reset)
		$onehot0(~nSlot));

endmodule

// ==== src/neoIoTop.sv ====
`timescale 1ns/100ps

`include "io_params.svh"

module neoIoTop
(
	input  logic                      nBITWD0,
	input  logic                      reset,
	input  logic                      wbCyc,
	input  logic                      wbStb,
	input  logic                      wbWe,
	input  logic [`IO_ADDR_W-1:0]     wbAdr,
	input  logic [`IO_DATA_W-1:0]     wbDatIn,
	output logic [`IO_DATA_W-1:0]     wbDatOut,
	output logic                      wbAck,
	input  logic [`IO_DATA_W-1:0]     dipSw,
	input  logic                      rtcDout,
	input  logic                      rtcTp,
	input  logic                      systemB,
	output logic [`IO_SLOT_COUNT-1:0] nSlot,
	output logic                      slotA,
	output logic                      slotB,
	output logic                      slotC,
	output logic [2:0]                ledLatch,
	output logic [`IO_DATA_W-1:0]     ledData,
	output logic                      rtcDin,
	output logic                      rtcClk,
	output logic                      rtcStrobe
);

	import ioPkg::*;

	regSel                 sel;
	logic                  wrEn;
	logic [`IO_DATA_W-1:0] rdData;
	logic [`IO_DATA_W-1:0] dipSync;
	logic [`IO_DATA_W-1:0] statusByte;
	logic                  systemBSync;
	logic [2:0]            slotCode;
	logic [2:0]            ledLatchReg;
	logic [`IO_DATA_W-1:0] ledDataReg;
	logic [2:0]            rtcCtrlReg;

	// Host side
	busSlave busSlaveInst (.nBITWD0, .reset, .wbCyc, .wbStb, .wbWe, .wbAdr,
		.wbDatOut, .wbAck, .sel, .wrEn, .rdData);

	// Board inputs
	inputSync inputSyncInst (.nBITWD0, .reset, .dipSw, .rtcDout, .rtcTp, .systemB,
		.dipSync, .statusByte, .systemBSync);

	ioRegisters ioRegistersInst (.nBITWD0, .reset, .wrEn, .sel, .wrData(wbDatIn),
		.dipSync, .statusByte, .rdData, .slotCode, .ledLatchReg, .ledDataReg,
		.rtcCtrlReg);

	// Board outputs
	boardOutputs boardOutputsInst (.nBITWD0, .reset, .slotCode, .systemBSync,
		.ledLatchReg, .ledDataReg, .rtcCtrlReg, .nSlot, .slotA, .slotB, .slotC,
		.ledLatch, .ledData, .rtcDin, .rtcClk, .rtcStrobe);

endmodule

// ==== dv/tbChecker.sv ====
`timescale 1ns/100ps

module tbChecker
(
	input  logic       nBITWD0,
	input  logic       wbAck,
	input  logic [7:0] wbDatOut,
	input  logic [5:0] nSlot,
	input  logic       slotA,
	input  logic       slotB,
	input  logic       slotC,
	input  logic [2:0] ledLatch,
	input  logic [7:0] ledData,
	input  logic       rtcDin,
	input  logic       rtcClk,
	input  logic       rtcStrobe,
	input  logic [8:0] expSlots,      // {nSlot, slotC, slotB, slotA}
	input  logic [2:0] expLedLatch,
	input  logic [7:0] expLedData,
	input  logic [2:0] expRtc,        // {strobe, clk, din}
	input  logic [7:0] expRead,
	input  logic       checkOuts,     // Compare board outputs this cycle
	input  logic       readCheck,     // Compare read data at ack
	input  logic       testEnd,
	input  int         testNum,
	input  int         reqCount,      // Requests issued so far
	input  logic       allDone,
	output int         errorCount
);

	int   testErrors = 0;
	int   errTotal = 0;
	int   testsRun = 0;
	int   ackCount = 0;
	logic ackSeen = 1'b0;   // Ack at the previous sample

	assign errorCount = errTotal;

	function automatic string testName(input int num);
		case (num)
			1:       return "reset values";
			2:       return "slot select";
			3:       return "LED and calendar registers";
			4:       return "read paths";
			5:       return "handshake";
			default: return "unknown";
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [7:0] expVal,
		input logic [7:0] actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL %0t %s expected %h actual %h", $time, name, expVal, actVal);
			testErrors++;
			errTotal++;
		end
	endtask

	// Mid cycle, DUT outputs and stimulus are both settled here
	always @(negedge nBITWD0)
	begin
		if (wbAck)
		begin
			ackCount++;
			if (ackSeen)
			begin
				$display("At %0t wbAck stayed high for a second cycle", $time);
				testErrors++;
				errTotal++;
			end
			if (readCheck)
				compareValue("wbDatOut", expRead, wbDatOut);   // Read data in ack cycle
		end
		ackSeen = wbAck;
		if (checkOuts)
		begin
			compareValue("wbAck", 8'h00, {7'b0, wbAck});   // No request open
			compareValue("nSlot", {2'b00, expSlots[8:3]}, {2'b00, nSlot});
			compareValue("slotLines", {5'b0, expSlots[2:0]}, {5'b0, slotC, slotB, slotA});
			compareValue("ledLatch", {5'b0, expLedLatch}, {5'b0, ledLatch});
			compareValue("ledData", expLedData, ledData);
			compareValue("rtcLines", {5'b0, expRtc}, {5'b0, rtcStrobe, rtcClk, rtcDin});
		end
		if (testEnd)
		begin
			// One ack per request
			if (ackCount != reqCount)
			begin
				$display("Saw %0d acks for %0d requests by the end of test %0d",
					ackCount, reqCount, testNum);
				testErrors++;
				errTotal++;
			end
			$display("test %0d %s: %s", testNum, testName(testNum),
				testErrors == 0 ? "ok" : "failed");
			testsRun++;
			testErrors = 0;
		end
		if (allDone)
			$display("tests run %0d, errors %0d", testsRun, errTotal);
	end

endmodule

// ==== dv/tbTop.sv ====
`timescale 1ns/100ps

module tbTop;

	localparam int NumTrans = 80;
	localparam int WatchCycles = NumTrans * 10 + 100;

	logic       nBITWD0 = 1'b0;
	logic       reset;
	logic       wbCyc;
	logic       wbStb;
	logic       wbWe;
	logic [3:0] wbAdr;
	logic [7:0] wbDatIn;
	logic [7:0] wbDatOut;
	logic       wbAck;
	logic [7:0] dipSw;
	logic       rtcDout;
	logic       rtcTp;
	logic       systemB;
	logic [5:0] nSlot;
	logic       slotA;
	logic       slotB;
	logic       slotC;
	logic [2:0] ledLatch;
	logic [7:0] ledData;
	logic       rtcDin;
	logic       rtcClk;
	logic       rtcStrobe;

	logic [2:0] modelSlot;   // Slot code the DUT should hold
	logic [8:0] expSlots;
	logic [2:0] expLedLatch;
	logic [7:0] expLedData;
	logic [2:0] expRtc;
	logic [7:0] expRead;
	logic       checkOuts;
	logic       readCheck;
	logic       testEnd;
	logic       allDone;
	int         testNum;
	int         reqCount;
	int         errorCount;
	integer     seed = 32'hba99_4666;

	always #10 nBITWD0 = ~nBITWD0;   // 20 ns period

	neoIoTop dut_i (.*);

	tbChecker checker_i (.*);

	// Slot rule, one enable low for codes 0 to 5, nothing without systemB
	function automatic logic [8:0] expectedOutputs(input logic [2:0] slot, input logic sysB);
		logic [5:0] enables;
		case (slot)
			3'd0:    enables = 6'b111110;
			3'd1:    enables = 6'b111101;
			3'd2:    enables = 6'b111011;
			3'd3:    enables = 6'b110111;
			3'd4:    enables = 6'b101111;
			3'd5:    enables = 6'b011111;
			default: enables = 6'b111111;   // Codes 6 and 7
		endcase
		if (sysB)
			return {enables, slot};
		return {6'b111111, 3'b000};
	endfunction

	assign expSlots = expectedOutputs(modelSlot, systemB);

	// One Wishbone request, stb kept up for hold cycles past the ack
	task automatic busCycle(input logic we, input logic [3:0] adr, input logic [7:0] data,
		input logic [7:0] readExp, input int hold);
		@(posedge nBITWD0);
		#2;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatIn = data;
		expRead = readExp;
		readCheck = !we;
		reqCount++;
		@(negedge nBITWD0);
		while (!wbAck)
			@(negedge nBITWD0);
		repeat (hold) @(posedge nBITWD0);
		@(posedge nBITWD0);
		#2;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		readCheck = 1'b0;
	endtask

	task automatic busWrite(input logic [3:0] adr, input logic [7:0] data, input int hold);
		busCycle(1'b1, adr, data, 8'h00, hold);
	endtask

	task automatic busRead(input logic [3:0] adr, input logic [7:0] expVal, input int hold);
		busCycle(1'b0, adr, 8'h00, expVal, hold);
	endtask

	// Checker compares the outputs during the next full cycle
	task automatic checkNow();
		@(posedge nBITWD0);
		#2;
		checkOuts = 1'b1;
		@(posedge nBITWD0);
		#2;
		checkOuts = 1'b0;
	endtask

	task automatic endTest(input int num);
		@(posedge nBITWD0);
		#2;
		testNum = num;
		testEnd = 1'b1;
		@(posedge nBITWD0);
		#2;
		testEnd = 1'b0;
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [7:0]  d;
		int          pass;
		int          code;
		int          round;
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = 4'h0;
		wbDatIn = 8'h00;
		dipSw = 8'h00;
		rtcDout = 1'b0;
		rtcTp = 1'b0;
		systemB = 1'b1;
		modelSlot = 3'd0;
		expLedLatch = 3'd0;
		expLedData = 8'h00;
		expRtc = 3'd0;
		expRead = 8'h00;
		checkOuts = 1'b0;
		readCheck = 1'b0;
		testEnd = 1'b0;
		allDone = 1'b0;
		testNum = 0;
		reqCount = 0;
		repeat (16) @(posedge nBITWD0);
		#2;
		reset = 1'b0;

		checkNow();   // Reset values
		endTest(1);

		// Every code, first with systemB high then low
		for (pass = 0; pass < 2; pass++)
		begin
			@(posedge nBITWD0);
			#2;
			systemB = (pass == 0);
			repeat (4) @(posedge nBITWD0);   // Sync plus output flop
			for (code = 0; code < 8; code++)
			begin
				rnd = $random(seed);
				d = rnd[7:0];
				d[2:0] = code[2:0];   // Upper bits are don't care
				busWrite(4'h2, d, 0);
				modelSlot = code[2:0];
				checkNow();
				busRead(4'h2, {5'b00000, code[2:0]}, 0);
			end
		end
		@(posedge nBITWD0);
		#2;
		systemB = 1'b1;
		repeat (4) @(posedge nBITWD0);
		endTest(2);

		for (round = 0; round < 4; round++)
		begin
			rnd = $random(seed);
			busWrite(4'h3, rnd[7:0], 0);
			expLedLatch = rnd[5:3];   // Strobes in D5..D3
			busWrite(4'h4, rnd[15:8], 0);
			expLedData = rnd[15:8];
			busWrite(4'h5, rnd[23:16], 0);
			expRtc = rnd[18:16];
			checkNow();
			busRead(4'h3, {5'b00000, expLedLatch}, 0);
			busRead(4'h4, expLedData, 0);
			busRead(4'h5, {5'b00000, expRtc}, 0);
		end
		endTest(3);

		for (round = 0; round < 3; round++)
		begin
			rnd = $random(seed);
			@(posedge nBITWD0);
			#2;
			dipSw = rnd[7:0];
			rtcDout = rnd[8];
			rtcTp = rnd[9];
			repeat (3) @(posedge nBITWD0);
			busRead(4'h0, dipSw, 0);
			busRead(4'h8, 8'h40, 0);   // A7 set, system type
			busRead(4'h1, {rtcDout, rtcTp, 6'b111111}, 0);
			busRead(4'h6, 8'hFF, 0);
			busRead(4'hF, 8'hFF, 0);
		end
		endTest(4);

		// Long strobes, A7 ignored for slot, read only writes dropped
		busWrite(4'hA, 8'h05, 4);
		modelSlot = 3'd5;
		rnd = $random(seed);
		busWrite(4'h0, rnd[7:0], 3);
		busWrite(4'h8, rnd[15:8], 0);
		busWrite(4'h1, rnd[23:16], 2);
		busWrite(4'h7, rnd[31:24], 0);
		busWrite(4'h6, rnd[7:0], 1);
		checkNow();
		busRead(4'h2, 8'h05, 3);
		busRead(4'h4, expLedData, 2);
		busRead(4'h5, {5'b00000, expRtc}, 0);
		endTest(5);

		@(posedge nBITWD0);
		#2;
		allDone = 1'b1;
		@(posedge nBITWD0);
		#2;
		allDone = 1'b0;
		@(posedge nBITWD0);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog sized from the transaction count
	initial
	begin
		repeat (WatchCycles) @(posedge nBITWD0);
		$display("Timeout after %0d clock periods, the tests did not finish", WatchCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+src
src/ioPkg.sv
src/busSlave.sv
src/inputSync.sv
src/ioRegisters.sv
src/boardOutputs.sv
src/neoIoTop.sv
dv/tbChecker.sv
dv/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -f files.f --top-module tbTop -o tbSim &&
simOut="$(./obj_dir/tbSim)" &&
echo "$simOut" &&
echo "$simOut" | grep -q "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
